// ==== design/core_pkg.sv ====
package core_pkg;

    localparam int unsigned xlen          = 32;
    localparam int unsigned reg_addr_bits = 5;

    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_branch = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_or  = 4'd3,
        alu_xor = 4'd4,
        alu_slt = 4'd5,
        alu_sll = 4'd6,
        alu_srl = 4'd7
    } alu_op_e;

    // Operand source selects for forwarding
    localparam logic [1:0] fwd_reg    = 2'd0;
    localparam logic [1:0] fwd_ex_mem = 2'd1;
    localparam logic [1:0] fwd_wb     = 2'd2;

    typedef struct packed {
        logic [6:0]               funct7;
        logic [reg_addr_bits-1:0] rs2;
        logic [reg_addr_bits-1:0] rs1;
        logic [2:0]               funct3;
        logic [reg_addr_bits-1:0] rd;
        opcode_e                  opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0]              imm;
        logic [reg_addr_bits-1:0] rs1;
        logic [2:0]               funct3;
        logic [reg_addr_bits-1:0] rd;
        opcode_e                  opcode;
    } i_type_t;

    // Branch offset is scattered over the word
    typedef struct packed {
        logic                     imm_12;
        logic [5:0]               imm_10_5;
        logic [reg_addr_bits-1:0] rs2;
        logic [reg_addr_bits-1:0] rs1;
        logic [2:0]               funct3;
        logic [3:0]               imm_4_1;
        logic                     imm_11;
        opcode_e                  opcode;
    } b_type_t;

    typedef union packed {
        r_type_t r_type;
        i_type_t i_type;
        b_type_t b_type;
    } instr_u;

    localparam logic [31:0] nop_instr = 32'h0000_0013;  // addi x0, x0, 0

endpackage

// ==== design/alu.sv ====
`timescale 1ns/1ps

module alu
    import core_pkg::*;
(
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  alu_op_e         alu_op,
    output logic [xlen-1:0] result,
    output logic            zero
);

    logic [4:0] shamt;

    assign shamt = b[4:0];   // Larger shift amounts wrap

    always_comb begin
        case (alu_op)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_xor: result = a ^ b;
            alu_slt: result = xlen'($signed(a) < $signed(b));
            alu_sll: result = a << shamt;
            alu_srl: result = a >> shamt;
            default: result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

// ==== design/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage
    import core_pkg::*;
#(
    parameter logic [xlen-1:0] reset_vector = '0
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [31:0]     imem_data,
    input  logic            branch_taken,
    input  logic [xlen-1:0] branch_target,
    output logic [xlen-1:0] imem_addr,
    output logic [xlen-1:0] if_pc,
    output instr_u          if_instr
);

    logic [xlen-1:0] pc;
    logic [xlen-1:0] next_pc;

    assign imem_addr = pc;   // Memory answers in the same cycle
    assign next_pc   = branch_taken ? branch_target : pc + xlen'(4);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= reset_vector;
            if_instr <= nop_instr;
        end else begin
            pc       <= next_pc;
            if_instr <= branch_taken ? nop_instr : imem_data;  // Kill the wrong-path word
        end
    end

    // Fetch address travels with its word
    always_ff @(posedge clk) begin
        if_pc <= pc;
    end

endmodule

// ==== design/register_bank.sv ====
`timescale 1ns/1ps

module register_bank
    import core_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [reg_addr_bits-1:0] rs1,
    input  logic [reg_addr_bits-1:0] rs2,
    input  logic [reg_addr_bits-1:0] wb_rd,
    input  logic                     wb_reg_write,
    input  logic [xlen-1:0]          wb_data,
    output logic [xlen-1:0]          rs1_data,
    output logic [xlen-1:0]          rs2_data
);

    logic [xlen-1:0] regs [32];

    // Write-through so decode sees the value retiring this cycle
    function automatic logic [xlen-1:0] read_port(input logic [reg_addr_bits-1:0] addr);
        if (addr == '0)
            return '0;
        else if (wb_reg_write && wb_rd == addr)
            return wb_data;
        else
            return regs[addr];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1);
        rs2_data = read_port(rs2);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wb_reg_write && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

endmodule

// ==== design/main_controller.sv ====
`timescale 1ns/1ps

module main_controller
    import core_pkg::*;
(
    input  instr_u                   if_instr,
    output logic [reg_addr_bits-1:0] rs1,
    output logic [reg_addr_bits-1:0] rs2,
    output logic [reg_addr_bits-1:0] rd,
    output logic                     reg_write,
    output logic                     alu_src_imm,
    output logic                     is_branch,
    output logic                     branch_ne,
    output alu_op_e                  alu_op,
    output logic [xlen-1:0]          imm
);

    always_comb begin
        // Anything not matched below behaves as a bubble
        rs1         = '0;
        rs2         = '0;
        rd          = '0;
        reg_write   = 1'b0;
        alu_src_imm = 1'b0;
        is_branch   = 1'b0;
        branch_ne   = 1'b0;
        alu_op      = alu_add;
        imm         = '0;

        case (if_instr.r_type.opcode)
            op_reg: begin
                rs1       = if_instr.r_type.rs1;
                rs2       = if_instr.r_type.rs2;
                rd        = if_instr.r_type.rd;
                reg_write = 1'b1;
                case (if_instr.r_type.funct3)
                    3'b000:  alu_op = if_instr.r_type.funct7[5] ? alu_sub : alu_add;
                    3'b001:  alu_op = alu_sll;
                    3'b010:  alu_op = alu_slt;
                    3'b100:  alu_op = alu_xor;
                    3'b101:  alu_op = alu_srl;
                    3'b110:  alu_op = alu_or;
                    3'b111:  alu_op = alu_and;
                    default: reg_write = 1'b0;   // sltu not supported
                endcase
            end
            op_imm: begin
                rs1         = if_instr.i_type.rs1;
                rd          = if_instr.i_type.rd;
                alu_src_imm = 1'b1;
                imm         = {{(xlen-12){if_instr.i_type.imm[11]}}, if_instr.i_type.imm};
                reg_write   = 1'b1;
                case (if_instr.i_type.funct3)
                    3'b000:  alu_op = alu_add;
                    3'b010:  alu_op = alu_slt;
                    3'b100:  alu_op = alu_xor;
                    3'b110:  alu_op = alu_or;
                    3'b111:  alu_op = alu_and;
                    default: reg_write = 1'b0;   // Immediate shifts and sltiu dropped
                endcase
            end
            op_branch: begin
                rs1       = if_instr.b_type.rs1;
                rs2       = if_instr.b_type.rs2;
                alu_op    = alu_sub;             // Equality via the zero flag
                branch_ne = if_instr.b_type.funct3[0];
                is_branch = (if_instr.b_type.funct3[2:1] == 2'b00);  // beq, bne only
                imm       = {{(xlen-13){if_instr.b_type.imm_12}}, if_instr.b_type.imm_12,
                             if_instr.b_type.imm_11, if_instr.b_type.imm_10_5,
                             if_instr.b_type.imm_4_1, 1'b0};
            end
            default: ;
        endcase
    end

endmodule

// ==== design/data_forwarding.sv ====
`timescale 1ns/1ps

module data_forwarding
    import core_pkg::*;
(
    input  logic [reg_addr_bits-1:0] id_ex_rs1,
    input  logic [reg_addr_bits-1:0] id_ex_rs2,
    input  logic [reg_addr_bits-1:0] ex_mem_rd,
    input  logic                     ex_mem_reg_write,
    input  logic [reg_addr_bits-1:0] wb_rd,
    input  logic                     wb_reg_write,
    output logic [1:0]               fwd_a_sel,
    output logic [1:0]               fwd_b_sel
);

    // Youngest producer wins
    function automatic logic [1:0] pick_source(input logic [reg_addr_bits-1:0] rs);
        if (ex_mem_reg_write && ex_mem_rd != '0 && ex_mem_rd == rs)
            return fwd_ex_mem;
        else if (wb_reg_write && wb_rd != '0 && wb_rd == rs)
            return fwd_wb;
        else
            return fwd_reg;
    endfunction

    always_comb begin
        fwd_a_sel = pick_source(id_ex_rs1);
        fwd_b_sel = pick_source(id_ex_rs2);
    end

endmodule

// ==== design/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage
    import core_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [xlen-1:0]          if_pc,
    input  logic [reg_addr_bits-1:0] rs1,
    input  logic [reg_addr_bits-1:0] rs2,
    input  logic [reg_addr_bits-1:0] rd,
    input  logic                     reg_write,
    input  logic                     alu_src_imm,
    input  logic                     is_branch,
    input  logic                     branch_ne,
    input  alu_op_e                  alu_op,
    input  logic [xlen-1:0]          imm,
    input  logic [xlen-1:0]          rs1_data,
    input  logic [xlen-1:0]          rs2_data,
    input  logic [1:0]               fwd_a_sel,
    input  logic [1:0]               fwd_b_sel,
    input  logic [xlen-1:0]          wb_data,
    output logic [reg_addr_bits-1:0] id_ex_rs1,
    output logic [reg_addr_bits-1:0] id_ex_rs2,
    output logic                     branch_taken,
    output logic [xlen-1:0]          branch_target,
    output logic [reg_addr_bits-1:0] ex_mem_rd,
    output logic                     ex_mem_reg_write,
    output logic [xlen-1:0]          ex_mem_result
);

    logic [reg_addr_bits-1:0] id_ex_rd;
    logic                     id_ex_reg_write;
    logic                     id_ex_alu_src_imm;
    logic                     id_ex_is_branch;
    logic                     id_ex_branch_ne;
    alu_op_e                  id_ex_alu_op;
    logic [xlen-1:0]          id_ex_pc;
    logic [xlen-1:0]          id_ex_imm;
    logic [xlen-1:0]          id_ex_rs1_data;
    logic [xlen-1:0]          id_ex_rs2_data;
    logic [xlen-1:0]          op_a;
    logic [xlen-1:0]          op_b_reg;
    logic [xlen-1:0]          alu_result;
    logic                     alu_zero;

    function automatic logic [xlen-1:0] forward(input logic [1:0] sel,
                                                input logic [xlen-1:0] reg_val);
        case (sel)
            fwd_ex_mem: return ex_mem_result;
            fwd_wb:     return wb_data;
            default:    return reg_val;
        endcase
    endfunction

    // ID/EX control bubbles on reset and on a taken branch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex_rs1         <= '0;
            id_ex_rs2         <= '0;
            id_ex_rd          <= '0;
            id_ex_reg_write   <= 1'b0;
            id_ex_alu_src_imm <= 1'b1;
            id_ex_is_branch   <= 1'b0;
            id_ex_branch_ne   <= 1'b0;
            id_ex_alu_op      <= alu_add;
        end else if (branch_taken) begin
            id_ex_rs1         <= '0;
            id_ex_rs2         <= '0;
            id_ex_rd          <= '0;
            id_ex_reg_write   <= 1'b0;
            id_ex_alu_src_imm <= 1'b1;
            id_ex_is_branch   <= 1'b0;
            id_ex_branch_ne   <= 1'b0;
            id_ex_alu_op      <= alu_add;
        end else begin
            id_ex_rs1         <= rs1;
            id_ex_rs2         <= rs2;
            id_ex_rd          <= rd;
            id_ex_reg_write   <= reg_write;
            id_ex_alu_src_imm <= alu_src_imm;
            id_ex_is_branch   <= is_branch;
            id_ex_branch_ne   <= branch_ne;
            id_ex_alu_op      <= alu_op;
        end
    end

    always_ff @(posedge clk) begin
        id_ex_pc       <= if_pc;
        id_ex_imm      <= imm;
        id_ex_rs1_data <= rs1_data;
        id_ex_rs2_data <= rs2_data;
    end

    always_comb begin
        op_a     = forward(fwd_a_sel, id_ex_rs1_data);
        op_b_reg = forward(fwd_b_sel, id_ex_rs2_data);
    end

    alu u_alu (
        .a      (op_a),
        .b      (id_ex_alu_src_imm ? id_ex_imm : op_b_reg),
        .alu_op (id_ex_alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    assign branch_taken  = id_ex_is_branch & (alu_zero ^ id_ex_branch_ne);  // bne inverts
    assign branch_target = id_ex_pc + id_ex_imm;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem_rd        <= '0;
            ex_mem_reg_write <= 1'b0;
        end else begin
            ex_mem_rd        <= id_ex_rd;
            ex_mem_reg_write <= id_ex_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        ex_mem_result <= alu_result;
    end

endmodule

// ==== design/retire_stage.sv ====
`timescale 1ns/1ps

module retire_stage
    import core_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [reg_addr_bits-1:0] ex_mem_rd,
    input  logic                     ex_mem_reg_write,
    input  logic [xlen-1:0]          ex_mem_result,
    output logic [reg_addr_bits-1:0] wb_rd,
    output logic                     wb_reg_write,
    output logic [xlen-1:0]          wb_data,
    output logic                     retire_valid,
    output logic [reg_addr_bits-1:0] retire_rd,
    output logic [xlen-1:0]          retire_data
);

    // MEM/WB, the memory slot only delays by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_rd        <= '0;
            wb_reg_write <= 1'b0;
        end else begin
            wb_rd        <= ex_mem_rd;
            wb_reg_write <= ex_mem_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        wb_data <= ex_mem_result;
    end

    assign retire_valid = wb_reg_write && (wb_rd != '0);  // x0 writes are silent
    assign retire_rd    = wb_rd;
    assign retire_data  = wb_data;

endmodule

// ==== design/segmented_core.sv ====
`timescale 1ns/1ps

module segmented_core
    import core_pkg::*;
#(
    parameter logic [xlen-1:0] reset_vector = '0
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [31:0]              imem_data,
    output logic [xlen-1:0]          imem_addr,
    output logic                     retire_valid,
    output logic [reg_addr_bits-1:0] retire_rd,
    output logic [xlen-1:0]          retire_data
);

    // Fetch and decode
    logic [xlen-1:0]          if_pc;
    instr_u                   if_instr;
    logic [reg_addr_bits-1:0] rs1, rs2, rd;
    logic                     reg_write, alu_src_imm, is_branch, branch_ne;
    alu_op_e                  alu_op;
    logic [xlen-1:0]          imm;
    logic [xlen-1:0]          rs1_data, rs2_data;

    // Execute and later
    logic [reg_addr_bits-1:0] id_ex_rs1, id_ex_rs2;
    logic [1:0]               fwd_a_sel, fwd_b_sel;
    logic                     branch_taken;
    logic [xlen-1:0]          branch_target;
    logic [reg_addr_bits-1:0] ex_mem_rd, wb_rd;
    logic                     ex_mem_reg_write, wb_reg_write;
    logic [xlen-1:0]          ex_mem_result, wb_data;

    fetch_stage #(.reset_vector(reset_vector)) u_fetch (
        .clk, .rst_n, .imem_data, .branch_taken, .branch_target,
        .imem_addr, .if_pc, .if_instr
    );

    main_controller u_ctrl (
        .if_instr, .rs1, .rs2, .rd, .reg_write, .alu_src_imm,
        .is_branch, .branch_ne, .alu_op, .imm
    );

    register_bank u_regs (
        .clk, .rst_n, .rs1, .rs2, .wb_rd, .wb_reg_write, .wb_data,
        .rs1_data, .rs2_data
    );

    data_forwarding u_fwd (
        .id_ex_rs1, .id_ex_rs2, .ex_mem_rd, .ex_mem_reg_write,
        .wb_rd, .wb_reg_write, .fwd_a_sel, .fwd_b_sel
    );

    execute_stage u_ex (
        .clk, .rst_n, .if_pc, .rs1, .rs2, .rd, .reg_write, .alu_src_imm,
        .is_branch, .branch_ne, .alu_op, .imm, .rs1_data, .rs2_data,
        .fwd_a_sel, .fwd_b_sel, .wb_data, .id_ex_rs1, .id_ex_rs2,
        .branch_taken, .branch_target, .ex_mem_rd, .ex_mem_reg_write, .ex_mem_result
    );

    retire_stage u_retire (
        .clk, .rst_n, .ex_mem_rd, .ex_mem_reg_write, .ex_mem_result,
        .wb_rd, .wb_reg_write, .wb_data, .retire_valid, .retire_rd, .retire_data
    );

endmodule

// ==== verification/core_tb_program.svh ====
// emit(mnemonic, a, b, c): R-type a=rd b=rs1 c=rs2, I-type a=rd b=rs1 c=imm,
// branches a=rs1 b=rs2 c=byte offset; expect_retire(rd, data) in retire order
task automatic load_tests();
    start_test("imm_alu");
    emit("addi", 1, 0, -5);
    emit("andi", 2, 1, -16);
    emit("ori",  3, 0, -256);
    emit("xori", 4, 1, -1);
    emit("slti", 5, 1, -4);
    emit("slti", 6, 1, -6);
    emit("addi", 7, 0, 2047);
    emit("addi", 8, 0, -2048);
    expect_retire(1, 32'hffff_fffb);
    expect_retire(2, 32'hffff_fff0);
    expect_retire(3, 32'hffff_ff00);
    expect_retire(4, 32'h0000_0004);
    expect_retire(5, 32'h0000_0001);
    expect_retire(6, 32'h0000_0000);
    expect_retire(7, 32'h0000_07ff);
    expect_retire(8, 32'hffff_f800);

    start_test("reg_alu");
    emit("addi", 1, 0, 7);
    emit("addi", 2, 0, 12);
    emit("add",  3, 1, 2);
    emit("sub",  4, 1, 2);      // 7 - 12 wraps
    emit("and",  5, 1, 2);
    emit("or",   6, 1, 2);
    emit("xor",  7, 1, 2);
    emit("slt",  8, 4, 1);
    emit("slt",  9, 1, 4);
    emit("addi", 10, 0, 31);
    emit("sll",  11, 1, 10);
    emit("srl",  12, 4, 10);
    emit("addi", 13, 0, 35);    // Shift amount 35 acts as 3
    emit("sll",  14, 1, 13);
    emit("srl",  15, 4, 13);
    expect_retire(1, 32'd7);
    expect_retire(2, 32'd12);
    expect_retire(3, 32'd19);
    expect_retire(4, 32'hffff_fffb);
    expect_retire(5, 32'd4);
    expect_retire(6, 32'd15);
    expect_retire(7, 32'd11);
    expect_retire(8, 32'd1);
    expect_retire(9, 32'd0);
    expect_retire(10, 32'd31);
    expect_retire(11, 32'h8000_0000);
    expect_retire(12, 32'd1);
    expect_retire(13, 32'd35);
    expect_retire(14, 32'h0000_0038);
    expect_retire(15, 32'h1fff_ffff);

    start_test("forwarding");
    emit("addi", 1, 0, 5);
    emit("addi", 2, 1, 1);      // Distance one
    emit("add",  3, 1, 1);      // Distance two
    emit("add",  4, 1, 2);      // x1 at distance three
    emit("sub",  5, 4, 3);
    emit("addi", 1, 1, 100);
    emit("add",  6, 1, 1);
    emit("addi", 1, 0, 1);
    emit("addi", 1, 1, 1);
    emit("add",  7, 1, 6);      // Youngest x1 must win
    expect_retire(1, 32'd5);
    expect_retire(2, 32'd6);
    expect_retire(3, 32'd10);
    expect_retire(4, 32'd11);
    expect_retire(5, 32'd1);
    expect_retire(1, 32'd105);
    expect_retire(6, 32'd210);
    expect_retire(1, 32'd1);
    expect_retire(1, 32'd2);
    expect_retire(7, 32'd212);

    start_test("x0_writes");
    emit("addi", 0, 0, 99);
    emit("addi", 1, 0, 4);
    emit("add",  0, 1, 1);
    emit("add",  2, 0, 1);
    emit("or",   3, 0, 0);
    emit("add",  4, 0, 1);
    expect_retire(1, 32'd4);
    expect_retire(2, 32'd4);
    expect_retire(3, 32'd0);
    expect_retire(4, 32'd4);

    start_test("branches");
    emit("addi", 1, 0, 3);
    emit("addi", 2, 0, 3);
    emit("beq",  1, 2, 12);     // Taken to 0x14
    emit("addi", 3, 0, 1);
    emit("addi", 4, 0, 1);
    emit("addi", 5, 0, 5);
    emit("bne",  1, 5, 12);     // Taken to 0x24
    emit("addi", 6, 0, 1);
    emit("addi", 7, 0, 1);
    emit("beq",  1, 5, 16);     // Falls through
    emit("addi", 8, 0, 8);
    emit("bne",  1, 2, 16);     // Falls through
    emit("addi", 9, 8, 1);
    emit("addi", 10, 9, 1);
    expect_retire(1, 32'd3);
    expect_retire(2, 32'd3);
    expect_retire(5, 32'd5);
    expect_retire(8, 32'd8);
    expect_retire(9, 32'd9);
    expect_retire(10, 32'd10);

    start_test("loop");
    emit("addi", 1, 0, 0);
    emit("addi", 2, 0, 4);
    emit("add",  1, 1, 2);
    emit("addi", 2, 2, -1);
    emit("bne",  2, 0, -8);
    emit("addi", 3, 1, 0);
    expect_retire(1, 32'd0);
    expect_retire(2, 32'd4);
    expect_retire(1, 32'd4);
    expect_retire(2, 32'd3);
    expect_retire(1, 32'd7);
    expect_retire(2, 32'd2);
    expect_retire(1, 32'd9);
    expect_retire(2, 32'd1);
    expect_retire(1, 32'd10);
    expect_retire(2, 32'd0);
    expect_retire(3, 32'd10);
endtask

// ==== verification/core_tb.sv ====
`timescale 1ns/1ps

module core_tb;

    localparam int          num_tests    = 6;
    localparam int          prog_words   = 16;
    localparam int          max_retires  = 16;
    localparam int          reset_cycles = 4;
    localparam int          drain_cycles = 8;
    localparam logic [31:0] nop_word     = 32'h0000_0013;  // addi x0, x0, 0

    logic        clk = 1'b0;
    logic        rst_n;
    logic [31:0] imem_data;
    logic [31:0] imem_addr;
    logic        retire_valid;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;

    string       test_name [num_tests];
    logic [31:0] prog_mem  [num_tests][prog_words];
    int          n_instr   [num_tests];
    logic [4:0]  exp_rd    [num_tests][max_retires];
    logic [31:0] exp_data  [num_tests][max_retires];
    int          n_exp     [num_tests];
    int          build = -1;   // Row being filled
    int          cur;          // Row being run
    int          n_seen;
    logic        checking;
    int          value_errors;
    int          count_errors;
    int          table_errors;
    int          cycles;
    int          cycle_limit;

    segmented_core dut (
        .clk, .rst_n, .imem_data, .imem_addr, .retire_valid, .retire_rd, .retire_data
    );

    always #2 clk = ~clk;

    // Tiny assembler so the tables read as assembly
    function automatic logic [31:0] assemble(input string op, input int a, input int b,
                                             input int c);
        string       names [15];
        logic [2:0]  f3    [15];
        logic [12:0] off;
        int          k;
        names = '{"add", "sub", "sll", "slt", "xor", "srl", "or", "and",
                  "addi", "slti", "xori", "ori", "andi", "beq", "bne"};
        f3    = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd4, 3'd5, 3'd6, 3'd7,
                  3'd0, 3'd2, 3'd4, 3'd6, 3'd7, 3'd0, 3'd1};
        off   = c[12:0];
        k     = 0;
        while (k < 15 && names[k] != op)
            k++;
        assert (k < 15) else begin
            $display("Program table holds an unknown mnemonic %s", op);
            table_errors++;
        end
        if (k < 8)
            return {(k == 1) ? 7'h20 : 7'h00, c[4:0], b[4:0], f3[k], a[4:0], 7'b0110011};
        else if (k < 13)
            return {c[11:0], b[4:0], f3[k], a[4:0], 7'b0010011};
        else if (k < 15)
            return {off[12], off[10:5], b[4:0], a[4:0], f3[k], off[4:1], off[11], 7'b1100011};
        return nop_word;
    endfunction

    task automatic start_test(input string name);
        build++;
        test_name[build] = name;
        n_instr[build]   = 0;
        n_exp[build]     = 0;
        for (int i = 0; i < prog_words; i++)
            prog_mem[build][i] = nop_word;   // Unused slots run as bubbles
    endtask

    task automatic emit(input string op, input int a, input int b, input int c);
        prog_mem[build][n_instr[build]] = assemble(op, a, b, c);
        n_instr[build]++;
    endtask

    task automatic expect_retire(input int rd, input logic [31:0] data);
        exp_rd[build][n_exp[build]]   = rd[4:0];
        exp_data[build][n_exp[build]] = data;
        n_exp[build]++;
    endtask

    `include "core_tb_program.svh"

    function automatic logic [31:0] program_word(input int t, input logic [31:0] addr);
        if (addr[1:0] == 2'b00 && addr < prog_words * 4)
            return prog_mem[t][addr[31:2]];
        else
            return nop_word;
    endfunction

    // Instruction memory answers the current pc
    always @(posedge clk) begin
        #1;
        imem_data = program_word(cur, imem_addr);
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout: the run did not end within %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    // Retire checker samples away from the active edge
    always @(negedge clk) begin
        if (checking && retire_valid) begin
            assert (n_seen < n_exp[cur]) else begin
                $display("Test %s: unexpected extra retire to x%0d", test_name[cur], retire_rd);
                count_errors++;
            end
            if (n_seen < n_exp[cur]) begin
                assert (retire_rd === exp_rd[cur][n_seen]) else begin
                    $display("Error: test %s retire %0d rd expected x%0d actual x%0d",
                             test_name[cur], n_seen, exp_rd[cur][n_seen], retire_rd);
                    value_errors++;
                end
                assert (retire_data === exp_data[cur][n_seen]) else begin
                    $display("Error: test %s retire %0d data expected %h actual %h",
                             test_name[cur], n_seen, exp_data[cur][n_seen], retire_data);
                    value_errors++;
                end
            end
            n_seen++;
        end
    end

    task automatic run_test(input int t);
        int budget;
        int waited;
        budget = (n_instr[t] + n_exp[t] + drain_cycles) * 2;
        waited = 0;
        @(posedge clk);
        #1;
        checking = 1'b0;
        rst_n    = 1'b0;
        cur      = t;
        repeat (reset_cycles) @(posedge clk);
        #1;
        n_seen   = 0;
        checking = 1'b1;
        rst_n    = 1'b1;
        while (n_seen < n_exp[t] && waited < budget) begin
            @(posedge clk);
            waited++;
        end
        assert (n_seen >= n_exp[t]) else begin
            $display("Test %s: only %0d of %0d expected retires came out in time",
                     test_name[t], n_seen, n_exp[t]);
            count_errors++;
        end
        repeat (drain_cycles) @(posedge clk);   // Late extra retires still show up
    endtask

    initial begin
        rst_n        = 1'b0;
        imem_data    = nop_word;
        cur          = 0;
        n_seen       = 0;
        checking     = 1'b0;
        value_errors = 0;
        count_errors = 0;
        table_errors = 0;
        cycles       = 0;
        load_tests();
        cycle_limit = 0;
        for (int t = 0; t < num_tests; t++)
            cycle_limit += (n_instr[t] + n_exp[t] + drain_cycles + reset_cycles) * 2;
        for (int t = 0; t < num_tests; t++)
            run_test(t);
        $display("Ran %0d tests: %0d value errors, %0d retire count errors, %0d table errors",
                 num_tests, value_errors, count_errors, table_errors);
        if (value_errors == 0 && count_errors == 0 && table_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+verification
design/core_pkg.sv
design/alu.sv
design/fetch_stage.sv
design/register_bank.sv
design/main_controller.sv
design/data_forwarding.sv
design/execute_stage.sv
design/retire_stage.sv
design/segmented_core.sv
verification/core_tb.sv
